// File: hw/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// cpu word and address width
`define ICACHE_WORD_SIZE 16

// words per line and the offset field that picks one
`define ICACHE_LINE_WORDS 4
`define ICACHE_OFFSET_BITS 2

// direct mapped, four lines
`define ICACHE_INDEX_BITS 2
`define ICACHE_NUM_LINES (1 << `ICACHE_INDEX_BITS)

// whatever is left of the address above index and offset
`define ICACHE_TAG_BITS (`ICACHE_WORD_SIZE - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

// full line as fetched from memory, word 0 in the low bits
`define ICACHE_LINE_BITS (`ICACHE_LINE_WORDS * `ICACHE_WORD_SIZE)

`define ICACHE_COUNT_BITS 16

`endif

// File: hw/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // address split as the cache sees it, high bits first
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic [`ICACHE_INDEX_BITS-1:0]  index;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } icache_addr_fields_t;

    // same 16 bits, either as a plain word or by field
    typedef union packed {
        logic [`ICACHE_WORD_SIZE-1:0] raw;
        icache_addr_fields_t          fields;
    } icache_addr_t;

endpackage

// File: hw/icache_request_latch.sv
`timescale 1ns/1ps

module icache_request_latch (
    input  logic                     clk,
    input  logic                     reset_n,
    input  icache_pkg::icache_addr_t cpu_address,
    input  logic                     accept,
    output icache_pkg::icache_addr_t req_addr
);

    // captured on the accepting edge only
    // the cpu may move on to its next address after cpu_ready,
    // so a refill in progress keeps working from this copy
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            req_addr <= '0;
        end else if (accept) begin
            req_addr <= cpu_address;
        end
    end

endmodule

// File: hw/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tag_array (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [`ICACHE_INDEX_BITS-1:0] index,
    input  logic                          write_en,
    input  logic [`ICACHE_TAG_BITS-1:0]   write_tag,
    input  logic                          flush,
    output logic [`ICACHE_TAG_BITS-1:0]   read_tag,
    output logic                          read_valid
);

    logic [`ICACHE_TAG_BITS-1:0]  tags [`ICACHE_NUM_LINES];
    logic [`ICACHE_NUM_LINES-1:0] valid_bits;

    // tag storage and its registered read
    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[index] <= write_tag;
        end
        read_tag <= tags[index];
    end

    // valid bits, cleared by reset or flush
    // read sees the value from before a same-edge update
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_bits <= '0;
            read_valid <= 1'b0;
        end else begin
            if (flush) begin
                valid_bits <= '0;
            end else if (write_en) begin
                valid_bits[index] <= 1'b1;
            end
            read_valid <= valid_bits[index];
        end
    end

endmodule

// File: hw/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_data_array (
    input  logic                          clk,
    input  logic [`ICACHE_INDEX_BITS-1:0] index,
    input  logic                          write_en,
    input  logic [`ICACHE_LINE_BITS-1:0]  write_line,
    output logic [`ICACHE_LINE_BITS-1:0]  read_line
);

    logic [`ICACHE_LINE_BITS-1:0] lines [`ICACHE_NUM_LINES];

    // whole line replaced at once on a refill
    always_ff @(posedge clk) begin
        if (write_en) begin
            lines[index] <= write_line;
        end
    end

    // registered read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        read_line <= lines[index];
    end

endmodule

// File: hw/icache_fill_fsm.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_fill_fsm (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          cpu_valid,
    input  logic                          flush,
    input  icache_pkg::icache_addr_t      req_addr,
    input  logic [`ICACHE_TAG_BITS-1:0]   read_tag,
    input  logic                          read_valid,
    input  logic                          mem_ready,
    output logic                          accept,
    output logic [`ICACHE_INDEX_BITS-1:0] array_index,
    output logic                          array_write,
    output logic                          flush_go,
    output logic                          mem_read,
    output logic [`ICACHE_WORD_SIZE-1:0]  mem_address,
    output logic                          hit_strobe,
    output logic                          miss_strobe
);

    import icache_pkg::*;

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] COMPARE  = 2'd1;
    localparam logic [1:0] ALLOCATE = 2'd2;

    logic [1:0]   state;
    logic [1:0]   state_next;
    logic         reread;
    logic         tag_match;
    icache_addr_t line_addr;

    // one request at a time, flush only between requests
    assign accept   = (state == IDLE) && cpu_valid;
    assign flush_go = (state == IDLE) && flush;

    // arrays always look at the latched index
    assign array_index = req_addr.fields.index;

    // array outputs belong to the latched request once the re-read is done
    assign tag_match   = read_valid && (read_tag == req_addr.fields.tag);
    assign hit_strobe  = (state == COMPARE) && !reread && tag_match;
    assign miss_strobe = (state == COMPARE) && !reread && !tag_match;

    // line-aligned fetch address
    always_comb begin
        line_addr               = req_addr;
        line_addr.fields.offset = '0;
    end
    assign mem_address = line_addr.raw;

    // fetch held until memory answers, dropped during the re-read cycle
    assign mem_read    = (state == ALLOCATE) && !reread;
    assign array_write = mem_read && mem_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cpu_valid) begin
                    state_next = COMPARE;
                end
            end
            COMPARE: begin
                // first cycle after accept only reads the latched index
                if (!reread) begin
                    if (tag_match) begin
                        state_next = IDLE;
                    end else begin
                        state_next = ALLOCATE;
                    end
                end
            end
            ALLOCATE: begin
                // new line written last edge, arrays read it back now
                if (reread) begin
                    state_next = COMPARE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // arrays need one more edge after the latch or a refill write
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= IDLE;
            reread <= 1'b0;
        end else begin
            state  <= state_next;
            reread <= accept || array_write;
        end
    end

endmodule

// File: hw/icache_read_port.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_read_port (
    input  logic                          clk,
    input  logic                          reset_n,
    input  icache_pkg::icache_addr_t      req_addr,
    input  logic [`ICACHE_LINE_BITS-1:0]  read_line,
    input  logic                          hit_strobe,
    input  logic                          miss_strobe,
    output logic                          cpu_ready,
    output logic [`ICACHE_WORD_SIZE-1:0]  cpu_data,
    output logic [`ICACHE_COUNT_BITS-1:0] hit_count,
    output logic [`ICACHE_COUNT_BITS-1:0] miss_count
);

    logic [`ICACHE_WORD_SIZE-1:0] selected_word;
    logic                         miss_pending;

    // word 0 in the low bits of the line
    assign selected_word =
        read_line[req_addr.fields.offset * `ICACHE_WORD_SIZE +: `ICACHE_WORD_SIZE];

    always_ff @(posedge clk) begin
        if (hit_strobe) begin
            cpu_data <= selected_word;
        end
    end

    // a missed request ends on the re-compare hit, which is not a real hit
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cpu_ready    <= 1'b0;
            miss_pending <= 1'b0;
            hit_count    <= '0;
            miss_count   <= '0;
        end else begin
            cpu_ready <= hit_strobe;
            if (miss_strobe) begin
                miss_pending <= 1'b1;
                miss_count   <= miss_count + 1'b1;
            end else if (hit_strobe) begin
                miss_pending <= 1'b0;
                if (!miss_pending) begin
                    hit_count <= hit_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          cpu_valid,
    input  logic [`ICACHE_WORD_SIZE-1:0]  cpu_address,
    input  logic                          flush,
    output logic                          cpu_ready,
    output logic [`ICACHE_WORD_SIZE-1:0]  cpu_data,
    output logic                          mem_read,
    output logic [`ICACHE_WORD_SIZE-1:0]  mem_address,
    input  logic [`ICACHE_LINE_BITS-1:0]  mem_data,
    input  logic                          mem_ready,
    output logic [`ICACHE_COUNT_BITS-1:0] hit_count,
    output logic [`ICACHE_COUNT_BITS-1:0] miss_count
);

    import icache_pkg::*;

    icache_addr_t                  req_addr;
    logic                          accept;
    logic [`ICACHE_INDEX_BITS-1:0] array_index;
    logic                          array_write;
    logic                          flush_go;
    logic [`ICACHE_TAG_BITS-1:0]   read_tag;
    logic                          read_valid;
    logic [`ICACHE_LINE_BITS-1:0]  read_line;
    logic                          hit_strobe;
    logic                          miss_strobe;

    // decode
    icache_request_latch i_request_latch (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_address (cpu_address),
        .accept      (accept),
        .req_addr    (req_addr)
    );

    icache_tag_array i_tag_array (
        .clk        (clk),
        .reset_n    (reset_n),
        .index      (array_index),
        .write_en   (array_write),
        .write_tag  (req_addr.fields.tag),
        .flush      (flush_go),
        .read_tag   (read_tag),
        .read_valid (read_valid)
    );

    // refill data goes straight from memory into the line
    icache_data_array i_data_array (
        .clk        (clk),
        .index      (array_index),
        .write_en   (array_write),
        .write_line (mem_data),
        .read_line  (read_line)
    );

    // execute
    icache_fill_fsm i_fill_fsm (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .flush       (flush),
        .req_addr    (req_addr),
        .read_tag    (read_tag),
        .read_valid  (read_valid),
        .mem_ready   (mem_ready),
        .accept      (accept),
        .array_index (array_index),
        .array_write (array_write),
        .flush_go    (flush_go),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .hit_strobe  (hit_strobe),
        .miss_strobe (miss_strobe)
    );

    // result
    icache_read_port i_read_port (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_addr    (req_addr),
        .read_line   (read_line),
        .hit_strobe  (hit_strobe),
        .miss_strobe (miss_strobe),
        .cpu_ready   (cpu_ready),
        .cpu_data    (cpu_data),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

endmodule

// File: test/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;

    import icache_pkg::*;

    // every memory word is its own address xor this pattern
    localparam logic [`ICACHE_WORD_SIZE-1:0] MEM_PATTERN = 16'h3c5a;
    // falling edges from driving a hit request to seeing cpu_ready
    localparam int HIT_WAIT = 3;

    logic                          clk;
    logic                          reset_n;
    logic                          cpu_valid;
    logic [`ICACHE_WORD_SIZE-1:0]  cpu_address;
    logic                          flush;
    logic                          cpu_ready;
    logic [`ICACHE_WORD_SIZE-1:0]  cpu_data;
    logic                          mem_read;
    logic [`ICACHE_WORD_SIZE-1:0]  mem_address;
    logic [`ICACHE_LINE_BITS-1:0]  mem_data;
    logic                          mem_ready;
    logic [`ICACHE_COUNT_BITS-1:0] hit_count;
    logic [`ICACHE_COUNT_BITS-1:0] miss_count;

    // stimulus table, one request per entry
    icache_addr_t stim_addr [$];
    logic         stim_flush [$];
    logic         stim_hit [$];

    icache_addr_t                  cur_addr;
    int                            fetch_count;
    int                            mismatches;
    int                            failures;
    logic [31:0]                   lfsr_state;
    logic [`ICACHE_COUNT_BITS-1:0] exp_hits;
    logic [`ICACHE_COUNT_BITS-1:0] exp_misses;

    icache_top i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_address (cpu_address),
        .flush       (flush),
        .cpu_ready   (cpu_ready),
        .cpu_data    (cpu_data),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .mem_data    (mem_data),
        .mem_ready   (mem_ready),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    always #20 clk = ~clk;

    function automatic logic [`ICACHE_WORD_SIZE-1:0] mem_word(
        input logic [`ICACHE_WORD_SIZE-1:0] addr
    );
        return addr ^ MEM_PATTERN;
    endfunction

    // word 0 in the low bits
    function automatic logic [`ICACHE_LINE_BITS-1:0] mem_line(
        input logic [`ICACHE_WORD_SIZE-1:0] base
    );
        logic [`ICACHE_LINE_BITS-1:0] line;
        int                           w;
        for (w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            line[w*`ICACHE_WORD_SIZE +: `ICACHE_WORD_SIZE] =
                mem_word(base + `ICACHE_WORD_SIZE'(w));
        end
        return line;
    endfunction

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_word(
        input string                        name,
        input logic [`ICACHE_WORD_SIZE-1:0] expected,
        input logic [`ICACHE_WORD_SIZE-1:0] actual
    );
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(
        input string                         name,
        input logic [`ICACHE_COUNT_BITS-1:0] expected,
        input logic [`ICACHE_COUNT_BITS-1:0] actual
    );
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic add_entry(
        input logic [`ICACHE_WORD_SIZE-1:0] addr,
        input logic                         do_flush,
        input logic                         hit
    );
        icache_addr_t a;
        a.raw = addr;
        stim_addr.push_back(a);
        stim_flush.push_back(do_flush);
        stim_hit.push_back(hit);
    endtask

    // address, flush first, expected hit
    task automatic load_stimulus();
        // cold misses on all four lines
        add_entry(16'h1230, 1'b0, 1'b0);
        add_entry(16'h1232, 1'b0, 1'b1);
        add_entry(16'h1230, 1'b0, 1'b1);
        add_entry(16'h4564, 1'b0, 1'b0);
        add_entry(16'h4567, 1'b0, 1'b1);
        add_entry(16'h78a9, 1'b0, 1'b0);
        add_entry(16'h78a9, 1'b0, 1'b1);
        add_entry(16'h9bce, 1'b0, 1'b0);
        add_entry(16'h9bcd, 1'b0, 1'b1);
        // hits and misses right after a request to another line
        add_entry(16'h1231, 1'b0, 1'b1);
        add_entry(16'h1236, 1'b0, 1'b0);
        add_entry(16'h78aa, 1'b0, 1'b1);
        add_entry(16'h4565, 1'b0, 1'b0);
        // two tags fighting over line 3
        add_entry(16'hdefc, 1'b0, 1'b0);
        add_entry(16'h9bcf, 1'b0, 1'b0);
        add_entry(16'hdefd, 1'b0, 1'b0);
        add_entry(16'h9bcc, 1'b0, 1'b0);
        add_entry(16'h9bcc, 1'b0, 1'b1);
        // flush drops everything cached so far
        add_entry(16'h9bcd, 1'b1, 1'b0);
        add_entry(16'h1231, 1'b0, 1'b0);
        add_entry(16'h1233, 1'b0, 1'b1);
        add_entry(16'h4566, 1'b0, 1'b0);
        add_entry(16'h4565, 1'b0, 1'b1);
        add_entry(16'ha5a4, 1'b0, 1'b0);
        add_entry(16'ha5a6, 1'b0, 1'b1);
        add_entry(16'ha5a5, 1'b1, 1'b0);
        add_entry(16'ha5a7, 1'b0, 1'b1);
        add_entry(16'h0008, 1'b0, 1'b0);
        add_entry(16'h000b, 1'b0, 1'b1);
        add_entry(16'ha5a4, 1'b0, 1'b1);
    endtask

    // memory model, one line per fetch after a random delay of 1 to 8 cycles
    initial begin : memory_model
        icache_addr_t                 expected_line;
        logic [`ICACHE_WORD_SIZE-1:0] held_addr;
        int                           fetch_delay;
        int                           b;
        forever begin
            @(negedge clk);
            if (mem_read === 1'b1) begin
                held_addr = mem_address;
                fetch_count++;
                expected_line = cur_addr;
                expected_line.fields.offset = '0;
                check_word("mem_address", expected_line.raw, mem_address);
                if (mem_address[`ICACHE_OFFSET_BITS-1:0] != '0) begin
                    report_failure("line fetch address has nonzero offset bits");
                end
                fetch_delay = 1;
                for (b = 0; b < 3; b++) begin
                    lfsr_state = lfsr_next(lfsr_state);
                    if (lfsr_state[0]) begin
                        fetch_delay = fetch_delay + (1 << b);
                    end
                end
                repeat (fetch_delay - 1) begin
                    @(negedge clk);
                    if (mem_read !== 1'b1 || mem_address !== held_addr) begin
                        report_failure("mem_read or mem_address changed before mem_ready");
                    end
                end
                mem_data  = mem_line(held_addr);
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
                if (mem_read !== 1'b0) begin
                    report_failure("mem_read still high in the cycle after mem_ready");
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge clk);
        limit = stim_addr.size() * 16 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: test did not finish within %0d clock cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int waits;
        int i;
        clk         = 1'b0;
        reset_n     = 1'b0;
        cpu_valid   = 1'b0;
        cpu_address = '0;
        flush       = 1'b0;
        mem_data    = '0;
        mem_ready   = 1'b0;
        lfsr_state  = 32'h7591_ccc4;
        fetch_count = 0;
        mismatches  = 0;
        failures    = 0;
        exp_hits    = '0;
        exp_misses  = '0;
        cur_addr    = '0;
        load_stimulus();

        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        if (cpu_ready !== 1'b0 || mem_read !== 1'b0) begin
            report_failure("cpu_ready or mem_read not low after reset");
        end
        check_count("hit_count", '0, hit_count);
        check_count("miss_count", '0, miss_count);

        for (i = 0; i < stim_addr.size(); i++) begin
            if (stim_flush[i]) begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            cur_addr    = stim_addr[i];
            fetch_count = 0;
            cpu_valid   = 1'b1;
            cpu_address = cur_addr.raw;
            waits       = 0;
            do begin
                @(negedge clk);
                waits++;
            end while (cpu_ready !== 1'b1);
            cpu_valid = 1'b0;

            check_word("cpu_data", mem_word(cur_addr.raw), cpu_data);
            if (stim_hit[i]) begin
                exp_hits++;
                if (fetch_count != 0) begin
                    report_failure($sformatf("hit at %h fetched a line", cur_addr.raw));
                end
                if (waits != HIT_WAIT) begin
                    report_failure($sformatf("hit at %h answered after %0d cycles, not %0d",
                        cur_addr.raw, waits, HIT_WAIT));
                end
            end else begin
                exp_misses++;
                if (fetch_count != 1) begin
                    report_failure($sformatf("miss at %h made %0d line fetches, not one",
                        cur_addr.raw, fetch_count));
                end
            end
            check_count("hit_count", exp_hits, hit_count);
            check_count("miss_count", exp_misses, miss_count);
            @(negedge clk);
        end

        repeat (2) @(negedge clk);
        check_count("hit_count", exp_hits, hit_count);
        check_count("miss_count", exp_misses, miss_count);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: icache.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_request_latch.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_fill_fsm.sv
hw/icache_read_port.sv
hw/icache_top.sv
test/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, and grep the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module icache_tb -f icache.f \
    && ./obj_dir/Vicache_tb | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
    && echo "run_sim: test passed" \
    || { echo "run_sim: test failed"; exit 1; }
